// ==== hdl/fabric_pkg.sv ====
`default_nettype none

package fabric_pkg;

    localparam int XLEN = 32;
    localparam int BE_W = 4;

    // Byte address bits inside one 16 KB memory
    localparam int LOCAL_AW = 14;
    // PIM window is 16 MB
    localparam int PIM_AW = 24;

    localparam logic [XLEN-1:0] IMEM_BASE = 32'h1000_0000;
    localparam logic [XLEN-1:0] DMEM_BASE = 32'h2000_0000;
    localparam logic [XLEN-1:0] PIM_BASE = 32'h4000_0000;

    typedef enum logic {
        OP_READ = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    typedef enum logic [1:0] {
        REGION_IMEM = 2'd0,
        REGION_DMEM = 2'd1,
        REGION_PIM = 2'd2,
        REGION_NONE = 2'd3
    } region_e;

    // Mask bit i covers byte i of the word
    typedef struct packed {
        mem_op_e op;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic [BE_W-1:0] be;
    } bus_req_t;

    typedef struct packed {
        logic [XLEN-1:0] rdata;
        logic err;
    } bus_rsp_t;

    typedef struct packed {
        logic en;
        logic [BE_W-1:0] we;
        logic [LOCAL_AW-1:0] addr;
        logic [XLEN-1:0] wdata;
    } local_req_t;

endpackage

`default_nettype wire

// ==== hdl/sram_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_bank import fabric_pkg::*; #(
    parameter int WIDTH = XLEN,
    parameter int LANES = BE_W,
    parameter int MEM_WORDS = 4096
) (
    input logic clk_i,
    input logic en_i,
    input logic [LANES-1:0] we_i,
    input logic [$clog2(MEM_WORDS)-1:0] addr_i,
    input logic [WIDTH-1:0] wdata_i,
    output logic [WIDTH-1:0] rdata_o
);

    localparam int LANE_W = WIDTH / LANES;

    logic [WIDTH-1:0] mem [MEM_WORDS];

    // Lane-wise write
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            for (int i = 0; i < LANES; i++) begin
                if (we_i[i]) begin
                    mem[addr_i][i*LANE_W +: LANE_W] <= wdata_i[i*LANE_W +: LANE_W];
                end
            end
        end
    end

    // Output register only moves on a pure read
    always_ff @(posedge clk_i) begin
        if (en_i && (we_i == '0)) begin
            rdata_o <= mem[addr_i];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/imem_banked.sv ====
`timescale 1ns/1ps
`default_nettype none

module imem_banked import fabric_pkg::*; #(
    parameter int MEM_WORDS = 4096
) (
    input logic clk_i,
    input logic rv_rst_ni,
    input local_req_t req_i,
    output logic [XLEN-1:0] rdata_o
);

    localparam int AW = $clog2(MEM_WORDS);
    localparam int OFF_W = $clog2(BE_W);
    localparam int BYTE_W = XLEN / BE_W;

    logic [AW-1:0] word_idx;
    logic [OFF_W-1:0] offset;
    logic [OFF_W-1:0] offset_q;
    logic [BE_W-1:0][BYTE_W-1:0] bank_rdata;

    assign word_idx = req_i.addr[AW+1:2];
    assign offset = req_i.addr[OFF_W-1:0];

    // Bank b holds byte (b - offset) of the host word.
    // Banks below the offset sit one row further on
    for (genvar b = 0; b < BE_W; b++) begin : g_bank
        logic [OFF_W-1:0] lane;
        logic [AW-1:0] row;

        assign lane = OFF_W'(b) - offset;
        assign row = word_idx + AW'(b < offset);

        sram_bank #(
            .WIDTH     (BYTE_W),
            .LANES     (1),
            .MEM_WORDS (MEM_WORDS)
        ) bank_i (
            .clk_i   (clk_i),
            .en_i    (req_i.en),
            .we_i    (req_i.we[lane]),
            .addr_i  (row),
            .wdata_i (req_i.wdata[lane*BYTE_W +: BYTE_W]),
            .rdata_o (bank_rdata[b])
        );
    end

    // Offset of the last read, kept for the output rotation
    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            offset_q <= '0;
        end else if (req_i.en && (req_i.we == '0)) begin
            offset_q <= offset;
        end
    end

    // Back to little-endian byte order
    always_comb begin
        for (int i = 0; i < BE_W; i++) begin
            rdata_o[i*BYTE_W +: BYTE_W] = bank_rdata[OFF_W'(i) + offset_q];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pim_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module pim_port import fabric_pkg::*; (
    input logic clk_i,
    input logic rv_rst_ni,
    input logic we_i,
    input logic re_i,
    input logic [XLEN-1:0] addr_i,
    input logic [XLEN-1:0] wdata_i,
    input logic [XLEN-1:0] pim_rd_i,
    output logic [XLEN-1:0] pim_addr_o,
    output logic [XLEN-1:0] pim_wr_o,
    output logic [XLEN-1:0] rdata_o
);

    // Outputs toward the PIM controller
    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            pim_addr_o <= '0;
            pim_wr_o <= '0;
        end else if (we_i) begin
            pim_addr_o <= addr_i;
            pim_wr_o <= wdata_i;
        end
    end

    // Read value captured at the accepting edge
    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            rdata_o <= '0;
        end else if (re_i) begin
            rdata_o <= pim_rd_i;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/sys_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module sys_bus import fabric_pkg::*; (
    input logic clk_i,
    input logic rv_rst_ni,

    // Host side
    input logic req_valid_i,
    output logic req_ready_o,
    input bus_req_t req_i,
    output logic rsp_valid_o,
    input logic rsp_ready_i,
    output bus_rsp_t rsp_o,

    // Memories
    output local_req_t imem_req_o,
    input logic [XLEN-1:0] imem_rdata_i,
    output local_req_t dmem_req_o,
    input logic [XLEN-1:0] dmem_rdata_i,

    // PIM
    output logic pim_we_o,
    output logic pim_re_o,
    output logic [XLEN-1:0] pim_addr_o,
    output logic [XLEN-1:0] pim_wdata_o,
    input logic [XLEN-1:0] pim_rdata_i
);

    region_e region;
    logic accept;
    logic is_write;

    logic rsp_pending_q;
    region_e region_q;
    mem_op_e op_q;

    function automatic local_req_t route(input bus_req_t req, input logic sel);
        local_req_t r;
        r.en = sel;
        r.we = (sel && req.op == OP_WRITE) ? req.be : '0;
        r.addr = req.addr[LOCAL_AW-1:0];
        r.wdata = req.wdata;
        return r;
    endfunction

    // Address decode
    always_comb begin
        if (req_i.addr[XLEN-1:LOCAL_AW] == IMEM_BASE[XLEN-1:LOCAL_AW]) begin
            region = REGION_IMEM;
        end else if (req_i.addr[XLEN-1:LOCAL_AW] == DMEM_BASE[XLEN-1:LOCAL_AW]) begin
            region = REGION_DMEM;
        end else if (req_i.addr[XLEN-1:PIM_AW] == PIM_BASE[XLEN-1:PIM_AW]) begin
            region = REGION_PIM;
        end else begin
            region = REGION_NONE;
        end
    end

    // Free when idle or when the pending response leaves this cycle
    assign req_ready_o = !rsp_pending_q || rsp_ready_i;
    assign accept = req_valid_i && req_ready_o;
    assign is_write = (req_i.op == OP_WRITE);

    assign imem_req_o = route(req_i, accept && (region == REGION_IMEM));
    assign dmem_req_o = route(req_i, accept && (region == REGION_DMEM));

    assign pim_we_o = accept && (region == REGION_PIM) && is_write;
    assign pim_re_o = accept && (region == REGION_PIM) && !is_write;
    assign pim_addr_o = req_i.addr;
    assign pim_wdata_o = req_i.wdata;

    // Outstanding response
    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            rsp_pending_q <= 1'b0;
            region_q <= REGION_NONE;
            op_q <= OP_READ;
        end else if (accept) begin
            rsp_pending_q <= 1'b1;
            region_q <= region;
            op_q <= req_i.op;
        end else if (rsp_ready_i) begin
            rsp_pending_q <= 1'b0;
        end
    end

    assign rsp_valid_o = rsp_pending_q;

    // Writes and unmapped accesses return zero
    always_comb begin
        rsp_o.rdata = '0;
        rsp_o.err = (region_q == REGION_NONE);
        if (op_q == OP_READ) begin
            case (region_q)
                REGION_IMEM: rsp_o.rdata = imem_rdata_i;
                REGION_DMEM: rsp_o.rdata = dmem_rdata_i;
                REGION_PIM: rsp_o.rdata = pim_rdata_i;
                default: rsp_o.rdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mem_fabric_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_fabric_top import fabric_pkg::*; #(
    parameter int MEM_WORDS = 4096
) (
    input logic clk_i,
    input logic rv_rst_ni,

    input logic req_valid_i,
    output logic req_ready_o,
    input bus_req_t req_i,
    output logic rsp_valid_o,
    input logic rsp_ready_i,
    output bus_rsp_t rsp_o,

    // PIM controller
    output logic [XLEN-1:0] pim_addr_o,
    output logic [XLEN-1:0] pim_wr_o,
    input logic [XLEN-1:0] pim_rd_i
);

    localparam int DMEM_AW = $clog2(MEM_WORDS);

    local_req_t imem_req;
    local_req_t dmem_req;
    logic [XLEN-1:0] imem_rdata;
    logic [XLEN-1:0] dmem_rdata;

    logic pim_we;
    logic pim_re;
    logic [XLEN-1:0] pim_addr;
    logic [XLEN-1:0] pim_wdata;
    logic [XLEN-1:0] pim_rdata;

    sys_bus bus_i (
        .clk_i        (clk_i),
        .rv_rst_ni    (rv_rst_ni),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .req_i        (req_i),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_ready_i  (rsp_ready_i),
        .rsp_o        (rsp_o),
        .imem_req_o   (imem_req),
        .imem_rdata_i (imem_rdata),
        .dmem_req_o   (dmem_req),
        .dmem_rdata_i (dmem_rdata),
        .pim_we_o     (pim_we),
        .pim_re_o     (pim_re),
        .pim_addr_o   (pim_addr),
        .pim_wdata_o  (pim_wdata),
        .pim_rdata_i  (pim_rdata)
    );

    imem_banked #(
        .MEM_WORDS (MEM_WORDS)
    ) imem_i (
        .clk_i     (clk_i),
        .rv_rst_ni (rv_rst_ni),
        .req_i     (imem_req),
        .rdata_o   (imem_rdata)
    );

    // DMEM ignores the two low address bits
    sram_bank #(
        .WIDTH     (XLEN),
        .LANES     (BE_W),
        .MEM_WORDS (MEM_WORDS)
    ) dmem_i (
        .clk_i   (clk_i),
        .en_i    (dmem_req.en),
        .we_i    (dmem_req.we),
        .addr_i  (dmem_req.addr[DMEM_AW+1:2]),
        .wdata_i (dmem_req.wdata),
        .rdata_o (dmem_rdata)
    );

    pim_port pim_i (
        .clk_i      (clk_i),
        .rv_rst_ni  (rv_rst_ni),
        .we_i       (pim_we),
        .re_i       (pim_re),
        .addr_i     (pim_addr),
        .wdata_i    (pim_wdata),
        .pim_rd_i   (pim_rd_i),
        .pim_addr_o (pim_addr_o),
        .pim_wr_o   (pim_wr_o),
        .rdata_o    (pim_rdata)
    );

endmodule

`default_nettype wire

// ==== tb/tb_mem_fabric.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_fabric import fabric_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 10;
    localparam int MEM_WORDS = 4096;
    localparam logic [XLEN-1:0] MEM_BYTES = 32'h0000_4000;
    localparam logic [XLEN-1:0] PIM_BYTES = 32'h0100_0000;

    typedef struct packed {
        mem_op_e op;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic [BE_W-1:0] be;
        logic [XLEN-1:0] pim_rd;
        logic [1:0] stall;
    } entry_t;

    logic clk_i;
    logic rv_rst_ni;
    logic req_valid_i;
    logic req_ready_o;
    bus_req_t req_i;
    logic rsp_valid_o;
    logic rsp_ready_i;
    bus_rsp_t rsp_o;
    logic [XLEN-1:0] pim_addr_o;
    logic [XLEN-1:0] pim_wr_o;
    logic [XLEN-1:0] pim_rd_i;

    entry_t stim_q[$];
    // Byte model of IMEM and DMEM by bus address
    logic [7:0] mem_model [logic [XLEN-1:0]];
    logic [XLEN-1:0] rand_state;
    int cycles;
    int rsp_idx;
    int mismatches;
    int timeouts;

    mem_fabric_top #(
        .MEM_WORDS (MEM_WORDS)
    ) mem_fabric_top_i (
        .clk_i       (clk_i),
        .rv_rst_ni   (rv_rst_ni),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_i       (req_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_o       (rsp_o),
        .pim_addr_o  (pim_addr_o),
        .pim_wr_o    (pim_wr_o),
        .pim_rd_i    (pim_rd_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    function automatic logic [XLEN-1:0] next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    function automatic region_e target_of(input logic [XLEN-1:0] a);
        if (a >= IMEM_BASE && a < IMEM_BASE + MEM_BYTES) begin
            return REGION_IMEM;
        end
        if (a >= DMEM_BASE && a < DMEM_BASE + MEM_BYTES) begin
            return REGION_DMEM;
        end
        if (a >= PIM_BASE && a < PIM_BASE + PIM_BYTES) begin
            return REGION_PIM;
        end
        return REGION_NONE;
    endfunction

    // DMEM drops the low address bits
    // IMEM word starts at the byte itself
    function automatic logic [XLEN-1:0] first_byte(input logic [XLEN-1:0] a);
        if (target_of(a) == REGION_DMEM) begin
            return {a[XLEN-1:2], 2'b00};
        end
        return a;
    endfunction

    function automatic bus_rsp_t expect_rsp(input entry_t e);
        bus_rsp_t r;
        region_e tgt;
        tgt = target_of(e.addr);
        r.rdata = '0;
        r.err = (tgt == REGION_NONE);
        if (e.op == OP_READ) begin
            if (tgt == REGION_IMEM || tgt == REGION_DMEM) begin
                for (int i = 0; i < BE_W; i++) begin
                    r.rdata[i*8 +: 8] = mem_model[first_byte(e.addr) + 32'(i)];
                end
            end else if (tgt == REGION_PIM) begin
                r.rdata = e.pim_rd;
            end
        end
        return r;
    endfunction

    task automatic apply_write(input entry_t e);
        region_e tgt;
        tgt = target_of(e.addr);
        if (e.op == OP_WRITE && (tgt == REGION_IMEM || tgt == REGION_DMEM)) begin
            for (int i = 0; i < BE_W; i++) begin
                if (e.be[i]) begin
                    mem_model[first_byte(e.addr) + 32'(i)] = e.wdata[i*8 +: 8];
                end
            end
        end
    endtask

    task automatic report_mismatch(
        input string name,
        input logic [XLEN-1:0] got,
        input logic [XLEN-1:0] exp
    );
        mismatches++;
        $display("FAIL %s: got 0x%08h, expected 0x%08h (cycle %0d, entry %0d)",
                 name, got, exp, cycles, rsp_idx);
    endtask

    task automatic add_entry(
        input mem_op_e op,
        input logic [XLEN-1:0] addr,
        input logic [BE_W-1:0] be
    );
        entry_t e;
        logic [XLEN-1:0] r;
        e.op = op;
        e.addr = addr;
        e.be = be;
        e.wdata = next_rand();
        e.pim_rd = next_rand();
        r = next_rand();
        // Stall length from the upper LCG bits
        e.stall = r[17:16];
        stim_q.push_back(e);
    endtask

    task automatic build_table();
        add_entry(OP_WRITE, 32'h2000_0010, 4'hF);
        add_entry(OP_WRITE, 32'h2000_0020, 4'hF);
        add_entry(OP_READ, 32'h2000_0010, 4'hF);
        add_entry(OP_WRITE, 32'h2000_0013, 4'b0101);
        add_entry(OP_READ, 32'h2000_0012, 4'hF);
        add_entry(OP_WRITE, 32'h2000_0020, 4'b1000);
        add_entry(OP_READ, 32'h2000_0021, 4'hF);
        // IMEM background, then all four offsets
        add_entry(OP_WRITE, 32'h1000_0000, 4'hF);
        add_entry(OP_WRITE, 32'h1000_0100, 4'hF);
        add_entry(OP_WRITE, 32'h1000_0104, 4'hF);
        add_entry(OP_WRITE, 32'h1000_0108, 4'hF);
        add_entry(OP_WRITE, 32'h1000_0101, 4'hF);
        add_entry(OP_READ, 32'h1000_0101, 4'hF);
        add_entry(OP_READ, 32'h1000_0100, 4'hF);
        add_entry(OP_WRITE, 32'h1000_0106, 4'b1010);
        add_entry(OP_READ, 32'h1000_0106, 4'hF);
        add_entry(OP_READ, 32'h1000_0104, 4'hF);
        add_entry(OP_WRITE, 32'h1000_0107, 4'hF);
        add_entry(OP_READ, 32'h1000_0107, 4'hF);
        add_entry(OP_READ, 32'h1000_0103, 4'hF);
        add_entry(OP_READ, 32'h1000_0108, 4'hF);
        add_entry(OP_WRITE, 32'h4000_1234, 4'b0011);
        add_entry(OP_READ, 32'h4012_3450, 4'hF);
        add_entry(OP_WRITE, 32'h40FF_FFFC, 4'hF);
        add_entry(OP_READ, 32'h40FF_FFFC, 4'hF);
        // Unmapped writes followed by readbacks of their aliases
        add_entry(OP_WRITE, 32'h1000_4000, 4'hF);
        add_entry(OP_READ, 32'h1000_0000, 4'hF);
        add_entry(OP_WRITE, 32'h2000_4010, 4'hF);
        add_entry(OP_READ, 32'h2000_0010, 4'hF);
        add_entry(OP_READ, 32'h3000_0000, 4'hF);
        add_entry(OP_WRITE, 32'h0000_0000, 4'hF);
        add_entry(OP_READ, 32'h4100_0000, 4'hF);
        add_entry(OP_READ, 32'h1000_4004, 4'hF);
    endtask

    initial begin
        int n;
        int limit;
        int idx;
        int stall_left;
        logic exp_pending;
        bus_rsp_t exp_rsp;
        logic [XLEN-1:0] exp_pim_addr;
        logic [XLEN-1:0] exp_pim_wr;
        logic valid_drv;
        logic ready_drv;
        logic done;

        rv_rst_ni = 1'b0;
        req_valid_i = 1'b0;
        req_i = '0;
        rsp_ready_i = 1'b0;
        pim_rd_i = '0;
        rand_state = 32'd9471;
        cycles = 0;
        rsp_idx = -1;
        mismatches = 0;
        timeouts = 0;
        build_table();
        n = stim_q.size();
        limit = 20 * n + RESET_CYCLES;

        repeat (RESET_CYCLES) @(negedge clk_i);
        rv_rst_ni = 1'b1;
        @(negedge clk_i);

        if (req_ready_o !== 1'b1) report_mismatch("req_ready_o", 32'(req_ready_o), 32'h1);
        if (rsp_valid_o !== 1'b0) report_mismatch("rsp_valid_o", 32'(rsp_valid_o), 32'h0);
        if (pim_addr_o !== '0) report_mismatch("pim_addr_o", pim_addr_o, '0);
        if (pim_wr_o !== '0) report_mismatch("pim_wr_o", pim_wr_o, '0);

        idx = 0;
        stall_left = 0;
        exp_pending = 1'b0;
        exp_rsp = '0;
        exp_pim_addr = '0;
        exp_pim_wr = '0;
        done = 1'b0;

        while (!done) begin
            // Next request stays up until accepted
            valid_drv = (idx < n);
            ready_drv = !(exp_pending && stall_left > 0);
            if (!ready_drv) begin
                stall_left--;
            end
            req_valid_i = valid_drv;
            if (valid_drv) begin
                req_i.op = stim_q[idx].op;
                req_i.addr = stim_q[idx].addr;
                req_i.wdata = stim_q[idx].wdata;
                req_i.be = stim_q[idx].be;
                pim_rd_i = stim_q[idx].pim_rd;
            end else begin
                req_i = '0;
            end
            rsp_ready_i = ready_drv;

            @(negedge clk_i);
            cycles++;

            // rsp_ready_i is low only while a response waits
            if (ready_drv) begin
                exp_pending = 1'b0;
                if (valid_drv) begin
                    exp_rsp = expect_rsp(stim_q[idx]);
                    apply_write(stim_q[idx]);
                    if (stim_q[idx].op == OP_WRITE &&
                        target_of(stim_q[idx].addr) == REGION_PIM) begin
                        exp_pim_addr = stim_q[idx].addr;
                        exp_pim_wr = stim_q[idx].wdata;
                    end
                    exp_pending = 1'b1;
                    rsp_idx = idx;
                    stall_left = int'(stim_q[idx].stall);
                    idx++;
                end
            end

            if (rsp_valid_o !== exp_pending) begin
                report_mismatch("rsp_valid_o", 32'(rsp_valid_o), 32'(exp_pending));
            end
            if (req_ready_o !== (!exp_pending || rsp_ready_i)) begin
                report_mismatch("req_ready_o", 32'(req_ready_o),
                                32'(!exp_pending || rsp_ready_i));
            end
            if (exp_pending && rsp_o.rdata !== exp_rsp.rdata) begin
                report_mismatch("rsp_o.rdata", rsp_o.rdata, exp_rsp.rdata);
            end
            if (exp_pending && rsp_o.err !== exp_rsp.err) begin
                report_mismatch("rsp_o.err", 32'(rsp_o.err), 32'(exp_rsp.err));
            end
            if (pim_addr_o !== exp_pim_addr) begin
                report_mismatch("pim_addr_o", pim_addr_o, exp_pim_addr);
            end
            if (pim_wr_o !== exp_pim_wr) begin
                report_mismatch("pim_wr_o", pim_wr_o, exp_pim_wr);
            end

            if (idx >= n && !exp_pending && rsp_valid_o === 1'b0) begin
                done = 1'b1;
            end
            if (cycles > limit) begin
                $display("Timeout: requests did not complete within %0d cycles", limit);
                timeouts++;
                done = 1'b1;
            end
        end

        req_valid_i = 1'b0;
        rsp_ready_i = 1'b0;
        $display("Summary: %0d requests, %0d mismatches, %0d timeouts",
                 n, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mem_fabric_top.f ====
hdl/fabric_pkg.sv
hdl/sram_bank.sv
hdl/imem_banked.sv
hdl/pim_port.sv
hdl/sys_bus.sv
hdl/mem_fabric_top.sv
tb/tb_mem_fabric.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f mem_fabric_top.f \
    --top-module tb_mem_fabric \
    --Mdir obj_dir \
    -o sim_mem_fabric

output=$(./obj_dir/sim_mem_fabric)
echo "$output"

if echo "$output" | grep -qF '** PASS **'; then
    exit 0
fi
exit 1
